/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the posit multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module posit_mult_tb \
    -o posit_mult_sim \
    && ./obj_dir/posit_mult_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

/* sim.f */
verilog/posit_pkg.sv
verilog/posit_decode.sv
verilog/posit_shifter.sv
verilog/posit_frac_mult.sv
verilog/posit_round_encode.sv
verilog/posit_mult_ctrl.sv
verilog/posit_mult.sv
sim/tb_clock.sv
sim/posit_mult_tb.sv

/* sim/posit_mult_input.txt */
// Columns, all hex: in1 in2 expected_result expected_inf expected_zero
// Posit32 with es = 2, one operation per line
// Exact products
40000000 40000000 40000000 0 0
40000000 4C000000 4C000000 0 0
48000000 38000000 40000000 0 0
48000000 58000000 60000000 0 0
44000000 44000000 49000000 0 0
4C000000 4C000000 59000000 0 0
C0000000 48000000 B8000000 0 0
B8000000 B8000000 50000000 0 0
B8000000 44000000 B4000000 0 0
30000000 60000000 50000000 0 0
44000000 38000000 3C000000 0 0
60000000 60000000 70000000 0 0
38000000 38000000 30000000 0 0
B8000000 38000000 C0000000 0 0
C0000000 C0000000 40000000 0 0
40000000 7FFFFFFF 7FFFFFFF 0 0
00000001 40000000 00000001 0 0
// Zero and NaR operands
00000000 40000000 00000000 0 1
4C000000 00000000 00000000 0 1
80000001 00000000 00000000 0 1
80000000 40000000 80000000 1 0
80000000 00000000 80000000 1 0
00000000 80000000 80000000 1 0
80000000 80000000 80000000 1 0
// Rounding, ties to even and above half
40002000 40002000 40004000 0 0
40002000 40002001 40004002 0 0
40002000 40006000 40008002 0 0
BFFFE000 40002000 BFFFC000 0 0
7FFFFFC0 40800000 7FFFFFC0 0 0
7FFFFFC0 41800000 7FFFFFC2 0 0
7FFFFFC0 40800001 7FFFFFC1 0 0
// Saturation to maxpos and minpos
7FFFFFFF 7FFFFFFF 7FFFFFFF 0 0
00000001 00000001 00000001 0 0
80000001 7FFFFFFF 80000001 0 0
80000001 80000001 7FFFFFFF 0 0
FFFFFFFF 00000001 FFFFFFFF 0 0
00000001 FFFFFFFF FFFFFFFF 0 0

/* sim/posit_mult_tb.sv */
// ******************************
// Runs the default 32-bit es=2 multiplier only
// Vectors come from sim/posit_mult_input.txt, run from the project root
// ******************************

module posit_mult_tb;
    import posit_pkg::*;

    localparam int max_vectors  = 64;
    localparam int reset_cycles = 8;
    localparam int burst_len    = 8;               // Leading vectors sent back to back
    localparam string vec_file  = "sim/posit_mult_input.txt";

    logic        clk;
    logic        rst_n;
    logic        start;
    posit_word_t in1, in2;
    posit_word_t result;
    logic        inf, zero, done;

    // Vector table
    posit_word_t vec_in1 [max_vectors];
    posit_word_t vec_in2 [max_vectors];
    posit_word_t vec_result [max_vectors];
    bit          vec_inf [max_vectors];
    bit          vec_zero [max_vectors];
    int          n_vectors;

    // Expected results in issue order
    posit_word_t exp_result_q [$];
    bit          exp_inf_q [$];
    bit          exp_zero_q [$];
    int          start_cycle_q [$];              // Edge at which the DUT took each start

    int          cycle;
    int          cycle_limit;
    int          starts, dones;
    int          value_errors, other_errors;
    logic [31:0] lfsr;

    tb_clock #(.period(4)) u_clock (.clk(clk));

    posit_mult #(
        .nbits(posit_default_nbits),
        .es   (posit_default_es)
    ) u_posit_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .in1   (in1),
        .in2   (in2),
        .result(result),
        .inf   (inf),
        .zero  (zero),
        .done  (done)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic next_random_bit(output bit b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];                           // Newest bit
    endtask

    task automatic draw_gap(output int gap);
        bit b0, b1;
        next_random_bit(b0);
        next_random_bit(b1);
        gap = 2 * int'(b1) + int'(b0);            // 0 to 3 idle cycles
    endtask

    task automatic check_word(input string name, input posit_word_t got, input posit_word_t want);
        if (got !== want)
        begin
            $display("mismatch %s: got %h, expected %h", name, got, want);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want)
        begin
            $display("mismatch %s: got %h, expected %h", name, got, want);
            value_errors++;
        end
    endtask

    // Comment and blank lines fail the scan and are skipped
    task automatic read_vectors();
        int          fd;
        int          n;
        string       line;
        posit_word_t a, b, r;
        logic [31:0] fi, fz;
        n_vectors = 0;
        fd = $fopen(vec_file, "r");
        if (fd == 0)
        begin
            $display("could not open the vector file %s", vec_file);
            other_errors++;
            return;
        end
        while (!$feof(fd) && n_vectors < max_vectors)
        begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h", a, b, r, fi, fz);
            if (n == 5)
            begin
                vec_in1[n_vectors]    = a;
                vec_in2[n_vectors]    = b;
                vec_result[n_vectors] = r;
                vec_inf[n_vectors]    = fi[0];
                vec_zero[n_vectors]   = fz[0];
                n_vectors++;
            end
        end
        $fclose(fd);
        if (n_vectors == 0)
        begin
            $display("no vectors found in %s", vec_file);
            other_errors++;
        end
    endtask

    task automatic report_counts();
        $display("Summary: %0d value mismatches, %0d other errors, %0d starts, %0d done pulses",
                 value_errors, other_errors, starts, dones);
    endtask

    // Monitor, samples values from before each edge
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (done)
        begin
            dones++;
            if (starts == 0)
            begin
                $display("done went high before the first start at cycle %0d", cycle);
                other_errors++;
            end
            else if (exp_result_q.size() == 0)
            begin
                $display("done pulse at cycle %0d with no operation in flight", cycle);
                other_errors++;
            end
            else
            begin
                if (cycle - start_cycle_q[0] != posit_latency)
                begin
                    $display("done came %0d cycles after its start instead of %0d",
                             cycle - start_cycle_q[0], posit_latency);
                    other_errors++;
                end
                check_word("result", result, exp_result_q[0]);
                check_flag("inf", inf, exp_inf_q[0]);
                check_flag("zero", zero, exp_zero_q[0]);
                void'(exp_result_q.pop_front());
                void'(exp_inf_q.pop_front());
                void'(exp_zero_q.pop_front());
                void'(start_cycle_q.pop_front());
            end
        end
        if (start)
        begin
            start_cycle_q.push_back(cycle);
            starts++;
        end
    end

    // Stimulus and final verdict
    initial
    begin
        int gap;
        start        = 1'b0;
        in1          = '0;
        in2          = '0;
        rst_n        = 1'b0;
        cycle        = 0;
        starts       = 0;
        dones        = 0;
        value_errors = 0;
        other_errors = 0;
        lfsr         = 32'h59e31c77;
        read_vectors();
        cycle_limit = n_vectors * 4 + posit_latency + 20;

        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);               // Idle, done must stay low

        for (int i = 0; i < n_vectors; i++)
        begin
            start <= 1'b1;
            in1   <= vec_in1[i];
            in2   <= vec_in2[i];
            exp_result_q.push_back(vec_result[i]);
            exp_inf_q.push_back(vec_inf[i]);
            exp_zero_q.push_back(vec_zero[i]);
            @(posedge clk);
            gap = 0;
            if (i >= burst_len)
                draw_gap(gap);
            if (gap != 0)
            begin
                start <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        start <= 1'b0;

        repeat (posit_latency + 4) @(posedge clk);   // Drain the pipeline

        if (exp_result_q.size() != 0)
        begin
            $display("%0d operations never got a done pulse", exp_result_q.size());
            other_errors++;
        end
        if (dones != starts || starts != n_vectors)
        begin
            $display("counts disagree: %0d vectors, %0d starts, %0d done pulses",
                     n_vectors, starts, dones);
            other_errors++;
        end

        report_counts();
        if (value_errors == 0 && other_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog on the cycle budget
    initial
    begin
        @(posedge clk);
        while (cycle < cycle_limit)
            @(posedge clk);
        $display("run stopped at the cycle limit of %0d before all vectors finished", cycle_limit);
        report_counts();
        $display("Test failed");
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
// ******************************
// Free-running testbench clock, starts low
// ******************************

module tb_clock #(
    parameter int period = 4            // Full period in time units
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;    // Half period per phase

endmodule

/* verilog/posit_decode.sv */
// ******************************
// Combinational, no registers
// Fraction output has no hidden bit and is nbits-3-es wide
// ******************************

module posit_decode #(
    parameter int nbits = posit_pkg::posit_default_nbits,
    parameter int es    = posit_pkg::posit_default_es
) (
    input  logic [nbits-1:0]        word,
    output logic                    sign,
    output posit_pkg::posit_scale_t scale,
    output logic [nbits-4-es:0]     fraction,
    output logic                    zero,
    output logic                    nar
);
    import posit_pkg::*;

    localparam int run_w = $clog2(nbits);   // Holds a run of up to nbits-1

    logic [nbits-2:0] body;        // Magnitude without the sign bit
    logic [nbits-2:0] diff;        // Regime run turned into leading zeros
    logic [nbits-2:0] rest;        // Exponent and fraction, left aligned
    logic             regime_bit;
    logic [run_w-1:0] run_len;
    posit_scale_t     k;

    assign sign = word[nbits-1];
    assign zero = ~sign & ~|word[nbits-2:0];     // All-zero word
    assign nar  = sign & ~|word[nbits-2:0];      // 1 followed by zeros

    // Low bits of the two's complement equal the negated low bits
    assign body = sign ? -word[nbits-2:0] : word[nbits-2:0];

    assign regime_bit = body[nbits-2];
    assign diff       = body ^ {(nbits-1){regime_bit}};

    // Leading-bit detector on diff
    // Highest set bit wins since the loop runs upward
    always_comb
    begin
        run_len = run_w'(nbits - 1);             // Run fills the whole body
        for (int i = 0; i < nbits - 1; i++)
        begin
            if (diff[i])
                run_len = run_w'(nbits - 2 - i);
        end
    end

    // Strip the run and its terminating bit
    assign rest = (body << run_len) << 1;

    // Run of ones gives k = run-1, run of zeros gives k = -run
    assign k = regime_bit ? posit_scale_t'(run_len) - 1'b1 : -posit_scale_t'(run_len);

    assign scale    = (k <<< es) + posit_scale_t'(rest[nbits-2 -: es]);
    assign fraction = rest[nbits-2-es:2];        // Bottom two bits are always zero

endmodule

/* verilog/posit_frac_mult.sv */
// ******************************
// Stage 1, operand registers load on en1
// Truncated product bits fold into the fraction LSB as sticky
// ******************************

module posit_frac_mult #(
    parameter int nbits = posit_pkg::posit_default_nbits,
    parameter int es    = posit_pkg::posit_default_es
) (
    input  logic                    clk,
    input  logic                    en1,
    input  logic                    a_sign,
    input  posit_pkg::posit_scale_t a_scale,
    input  logic [nbits-4-es:0]     a_fraction,
    input  logic                    a_zero,
    input  logic                    a_nar,
    input  logic                    b_sign,
    input  posit_pkg::posit_scale_t b_scale,
    input  logic [nbits-4-es:0]     b_fraction,
    input  logic                    b_zero,
    input  logic                    b_nar,
    output logic                    prod_sign,
    output posit_pkg::posit_scale_t prod_scale,
    output logic [nbits-4:0]        prod_fraction,
    output logic                    prod_zero,
    output logic                    prod_nar
);
    import posit_pkg::*;

    localparam int frac_w = nbits - 3 - es;
    localparam int prod_w = 2 * frac_w + 2;      // Full product of two hidden-bit fractions
    localparam int out_w  = nbits - 3;
    localparam int ext_w  = prod_w - 1 + out_w;  // Zero padding keeps the sticky slice non-empty

    logic               s1_a_sign, s1_b_sign;
    posit_scale_t       s1_a_scale, s1_b_scale;
    logic [frac_w-1:0]  s1_a_frac, s1_b_frac;
    logic               s1_a_zero, s1_b_zero, s1_a_nar, s1_b_nar;

    logic [frac_w:0]    hid_a, hid_b;
    logic [prod_w-1:0]  product;
    logic               norm;
    logic [prod_w-2:0]  aligned;
    logic [ext_w-1:0]   ext;

    always_ff @(posedge clk)
    begin
        if (en1)
        begin
            s1_a_sign  <= a_sign;
            s1_a_scale <= a_scale;
            s1_a_frac  <= a_fraction;
            s1_a_zero  <= a_zero;
            s1_a_nar   <= a_nar;
            s1_b_sign  <= b_sign;
            s1_b_scale <= b_scale;
            s1_b_frac  <= b_fraction;
            s1_b_zero  <= b_zero;
            s1_b_nar   <= b_nar;
        end
    end

    assign hid_a   = {1'b1, s1_a_frac};          // Restore hidden bits
    assign hid_b   = {1'b1, s1_b_frac};
    assign product = hid_a * hid_b;              // Value in [1, 4)

    // Product at or above 2 moves the radix point by one
    assign norm    = product[prod_w-1];
    assign aligned = norm ? product[prod_w-2:0] : {product[prod_w-3:0], 1'b0};
    assign ext     = {aligned, {out_w{1'b0}}};

    assign prod_fraction = {ext[ext_w-1 -: out_w-1], |ext[ext_w-out_w:0]};
    assign prod_scale    = s1_a_scale + s1_b_scale + posit_scale_t'(norm);
    assign prod_sign     = s1_a_sign ^ s1_b_sign;
    assign prod_zero     = s1_a_zero | s1_b_zero;
    assign prod_nar      = s1_a_nar | s1_b_nar;  // NaR wins over zero later

endmodule

/* verilog/posit_mult.sv */
// ******************************
// New operand pair every cycle, done follows start by 4 cycles
// Result must be taken in its done cycle
// ******************************

module posit_mult #(
    parameter int nbits = posit_pkg::posit_default_nbits,
    parameter int es    = posit_pkg::posit_default_es
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [nbits-1:0] in1,
    input  logic [nbits-1:0] in2,
    output logic [nbits-1:0] result,
    output logic             inf,
    output logic             zero,
    output logic             done
);
    import posit_pkg::*;

    localparam int frac_w = nbits - 3 - es;

    logic [nbits-1:0]  s0_in1, s0_in2;   // Stage-0 operands
    logic              en1, en2, en3;

    logic              a_sign, a_zero, a_nar;
    posit_scale_t      a_scale;
    logic [frac_w-1:0] a_fraction;
    logic              b_sign, b_zero, b_nar;
    posit_scale_t      b_scale;
    logic [frac_w-1:0] b_fraction;

    logic              prod_sign, prod_zero, prod_nar;
    posit_scale_t      prod_scale;
    logic [nbits-4:0]  prod_fraction;

    // Operands load with start and hold while idle
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            s0_in1 <= in1;
            s0_in2 <= in2;
        end
    end

    posit_mult_ctrl #(
        .nbits(nbits),
        .es   (es)
    ) u_ctrl (
        .clk  (clk),
        .rst_n(rst_n),
        .start(start),
        .en1  (en1),
        .en2  (en2),
        .en3  (en3),
        .done (done)
    );

    posit_decode #(
        .nbits(nbits),
        .es   (es)
    ) u_decode_a (
        .word    (s0_in1),
        .sign    (a_sign),
        .scale   (a_scale),
        .fraction(a_fraction),
        .zero    (a_zero),
        .nar     (a_nar)
    );

    posit_decode #(
        .nbits(nbits),
        .es   (es)
    ) u_decode_b (
        .word    (s0_in2),
        .sign    (b_sign),
        .scale   (b_scale),
        .fraction(b_fraction),
        .zero    (b_zero),
        .nar     (b_nar)
    );

    posit_frac_mult #(
        .nbits(nbits),
        .es   (es)
    ) u_frac_mult (
        .clk          (clk),
        .en1          (en1),
        .a_sign       (a_sign),
        .a_scale      (a_scale),
        .a_fraction   (a_fraction),
        .a_zero       (a_zero),
        .a_nar        (a_nar),
        .b_sign       (b_sign),
        .b_scale      (b_scale),
        .b_fraction   (b_fraction),
        .b_zero       (b_zero),
        .b_nar        (b_nar),
        .prod_sign    (prod_sign),
        .prod_scale   (prod_scale),
        .prod_fraction(prod_fraction),
        .prod_zero    (prod_zero),
        .prod_nar     (prod_nar)
    );

    posit_round_encode #(
        .nbits(nbits),
        .es   (es)
    ) u_round_encode (
        .clk          (clk),
        .en2          (en2),
        .en3          (en3),
        .prod_sign    (prod_sign),
        .prod_scale   (prod_scale),
        .prod_fraction(prod_fraction),
        .prod_zero    (prod_zero),
        .prod_nar     (prod_nar),
        .result       (result),
        .inf          (inf),
        .zero         (zero)
    );

endmodule

/* verilog/posit_mult_ctrl.sv */
// ******************************
// Valid chain only, no back-pressure
// Parameters are checked, es must be 2 or more
// ******************************

module posit_mult_ctrl #(
    parameter int nbits = posit_pkg::posit_default_nbits,
    parameter int es    = posit_pkg::posit_default_es
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic en1,
    output logic en2,
    output logic en3,
    output logic done
);
    import posit_pkg::*;

    logic [posit_latency-1:0] valid;   // valid[i] marks live data in stage i

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid <= '0;
        end
        else
        begin
            valid <= {valid[posit_latency-2:0], start};  // Advance one stage per cycle
        end
    end

    // A stage loads when the stage before holds a live operation
    assign en1  = valid[0];
    assign en2  = valid[1];
    assign en3  = valid[2];
    assign done = valid[posit_latency-1];

    // Every start yields a done after the fixed latency
    assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##posit_latency done);

    // And no done appears without its start
    assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(start, posit_latency));

    // Configuration within the package bounds
    assert property (@(posedge clk)
        nbits >= 8 && nbits <= posit_max_nbits && es >= 2 && es <= posit_max_es);

endmodule

/* verilog/posit_pkg.sv */
// ******************************
// Shared posit types and limits
// The scale type covers products for nbits up to 32 and es up to 3
// ******************************

package posit_pkg;

    // Parameter limits of the multiplier
    localparam int posit_max_nbits = 32;
    localparam int posit_max_es    = 3;

    // Default configuration of the top level
    localparam int posit_default_nbits = 32;
    localparam int posit_default_es    = 2;

    // Start-to-done distance in clock cycles
    localparam int posit_latency = 4;

    // Scale width
    // Largest product scale is about 2 * (2^es * (nbits-1)) + 1
    localparam int posit_scale_bits = 10;

    // Posit word at the default size
    typedef logic [posit_default_nbits-1:0] posit_word_t;

    // Signed scale, 2^es * k + exponent
    typedef logic signed [posit_scale_bits-1:0] posit_scale_t;

endpackage

/* verilog/posit_round_encode.sv */
// ******************************
// Stages 2 and 3, loaded on en2 and en3
// Needs es >= 2 so the fraction holds after bit and sticky
// ******************************

module posit_round_encode #(
    parameter int nbits = posit_pkg::posit_default_nbits,
    parameter int es    = posit_pkg::posit_default_es
) (
    input  logic                    clk,
    input  logic                    en2,
    input  logic                    en3,
    input  logic                    prod_sign,
    input  posit_pkg::posit_scale_t prod_scale,
    input  logic [nbits-4:0]        prod_fraction,
    input  logic                    prod_zero,
    input  logic                    prod_nar,
    output logic [nbits-1:0]        result,
    output logic                    inf,
    output logic                    zero
);
    import posit_pkg::*;

    localparam int pack_w = 2 * nbits - 3 + es;  // Run, terminator, exponent, fraction
    localparam int amt_w  = $clog2(pack_w + 1);
    localparam int k_max  = nbits - 2;           // Regime of maxpos

    logic               s2_sign, s2_zero, s2_nar;
    posit_scale_t       s2_scale, s2_k, s2_run;
    logic [nbits-4:0]   s2_frac;
    logic               s2_neg;
    logic [amt_w-1:0]   s2_amt, s2_mask_amt;
    logic [pack_w-1:0]  s2_packed, s2_mask;
    logic               s2_after, s2_sticky;

    logic               s3_sign, s3_zero, s3_nar, s3_after, s3_sticky;
    posit_scale_t       s3_scale, s3_k;
    logic [pack_w-1:0]  s3_packed, s3_shifted;
    logic [amt_w-1:0]   s3_amt;
    logic [nbits-2:0]   s3_body, s3_mag;
    logic               s3_round_up;
    logic [nbits-1:0]   s3_signed;

    always_ff @(posedge clk)
    begin
        if (en2)
        begin
            s2_sign  <= prod_sign;
            s2_scale <= prod_scale;
            s2_frac  <= prod_fraction;
            s2_zero  <= prod_zero;
            s2_nar   <= prod_nar;
        end
    end

    assign s2_neg = s2_scale[$bits(posit_scale_t)-1];
    assign s2_k   = s2_scale >>> es;                      // Regime value
    assign s2_run = s2_neg ? -s2_k : s2_k + 1'b1;         // Regime run length

    // Right shift that leaves the run at the top of the body
    assign s2_amt      = s2_run[amt_w-1:0] + amt_w'(es - 1);
    assign s2_mask_amt = amt_w'(pack_w) - s2_amt;

    assign s2_packed = {{(nbits-1){~s2_neg}}, s2_neg, s2_scale[es-1:0], s2_frac};

    // Bits below the body move to the top, after bit first
    posit_shifter #(
        .width      (pack_w),
        .amount_bits(amt_w),
        .shift_left (1'b1)
    ) u_mask_shift (
        .data   (s2_packed),
        .amount (s2_mask_amt),
        .shifted(s2_mask)
    );

    assign s2_after  = s2_mask[pack_w-1];
    assign s2_sticky = |s2_mask[pack_w-2:0];

    always_ff @(posedge clk)
    begin
        if (en3)
        begin
            s3_sign   <= s2_sign;
            s3_scale  <= s2_scale;
            s3_zero   <= s2_zero;
            s3_nar    <= s2_nar;
            s3_packed <= s2_packed;
            s3_amt    <= s2_amt;
            s3_after  <= s2_after;
            s3_sticky <= s2_sticky;
        end
    end

    posit_shifter #(
        .width      (pack_w),
        .amount_bits(amt_w),
        .shift_left (1'b0)
    ) u_regime_shift (
        .data   (s3_packed),
        .amount (s3_amt),
        .shifted(s3_shifted)
    );

    assign s3_k        = s3_scale >>> es;
    assign s3_body     = s3_shifted[nbits-2:0];
    assign s3_round_up = s3_after & (s3_sticky | s3_body[0]);   // Ties go to even

    // Inward projection clamps to maxpos or minpos
    always_comb
    begin
        if (s3_k > k_max)
            s3_mag = '1;
        else if (s3_k < -k_max)
            s3_mag = {{(nbits-2){1'b0}}, 1'b1};
        else
            s3_mag = s3_body + s3_round_up;      // Cannot wrap, after bit of maxpos is 0
    end

    assign s3_signed = s3_sign ? -{1'b0, s3_mag} : {1'b0, s3_mag};

    assign result = s3_nar ? {1'b1, {(nbits-1){1'b0}}} : (s3_zero ? '0 : s3_signed);
    assign inf    = s3_nar;
    assign zero   = s3_zero & ~s3_nar;

    // Round-up never carries out of a full body inside the regime range
    assert property (@(posedge clk) $past(en3) && s3_k <= k_max && s3_k >= -k_max
        |-> !(&s3_body && s3_round_up));

    // A nonzero product never rounds or saturates into 0 or NaR
    assert property (@(posedge clk) $past(en3) && !inf && !zero |-> result[nbits-2:0] != '0);

endmodule

/* verilog/posit_shifter.sv */
// ******************************
// Logarithmic shifter, zeros shift in
// Amounts of width or more leave all zeros
// ******************************

module posit_shifter #(
    parameter int width       = 64,
    parameter int amount_bits = 7,
    parameter bit shift_left  = 1'b0
) (
    input  logic [width-1:0]       data,
    input  logic [amount_bits-1:0] amount,
    output logic [width-1:0]       shifted
);

    logic [width-1:0] stage [amount_bits+1];     // stage[i] has amount[i-1:0] applied

    assign stage[0] = data;

    // One level per amount bit, shifting by 2^i
    for (genvar i = 0; i < amount_bits; i++)
    begin : g_level
        if (shift_left)
        begin : g_left
            assign stage[i+1] = amount[i] ? (stage[i] << (2**i)) : stage[i];
        end
        else
        begin : g_right
            assign stage[i+1] = amount[i] ? (stage[i] >> (2**i)) : stage[i];
        end
    end

    assign shifted = stage[amount_bits];

endmodule
